// File: verilog/pp_pkg.sv
package pp_pkg;

   typedef logic [3:0] count_t;

   typedef enum logic {
      DIR_DOWN = 1'b0,
      DIR_UP   = 1'b1
   } dir_e;

   // Configuration from the register block
   typedef struct packed {
      logic   enable;
      count_t max;
      count_t min;
   } counter_cfg_t;

   typedef struct packed {
      count_t count;
      dir_e   dir;
   } counter_state_t;

   // Wishbone classic, master to slave
   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      logic [1:0] adr;
      logic [7:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic       ack;
      logic [7:0] dat;
   } wb_rsp_t;

   typedef enum logic [1:0] {
      REG_CTRL   = 2'd0,   // Bit 0 enable
      REG_LIMITS = 2'd1,   // Max in high nibble, min in low nibble
      REG_STATUS = 2'd2,   // Count and direction, read only
      REG_CMD    = 2'd3    // Flip and restart strobes
   } reg_addr_e;

   typedef enum logic {
      DIGIT_NUMBER = 1'b0,
      DIGIT_ARROW  = 1'b1
   } digit_kind_e;

   typedef logic [7:0] seg_t;   // Active low, bit 7 is the point

   localparam int DEBOUNCE_SAMPLES = 4;

endpackage

// File: verilog/tick_gen.sv
module tick_gen #(
   parameter int DIV = 16
) (
   input  logic clk,
   input  logic rst_n,
   output logic tick
);

   localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
   localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1);

   logic [CNT_W-1:0] cnt;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt  <= '0;
         tick <= 1'b0;
      end else begin
         tick <= (cnt == LAST);   // Registered so the first tick lands in cycle DIV
         if (cnt == LAST)
            cnt <= '0;
         else
            cnt <= cnt + 1'b1;
      end
   end

   a_tick_single : assert property (@(posedge clk) disable iff (!rst_n)
      (DIV > 1) && tick |=> !tick);

endmodule

// File: verilog/button_conditioner.sv
module button_conditioner (
   input  logic clk,
   input  logic rst_n,
   input  logic sample,
   input  logic btn,
   output logic pulse
);

   import pp_pkg::*;

   logic [1:0]                  btn_sync;
   logic [DEBOUNCE_SAMPLES-1:0] history;   // Newest sample in bit 0
   logic                        level;
   logic                        level_d;

   // Two-flop synchronizer for the raw pin
   always_ff @(posedge clk) begin
      if (!rst_n)
         btn_sync <= 2'b00;
      else
         btn_sync <= {btn_sync[0], btn};
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         history <= '0;
      end else if (sample) begin
         history <= {history[DEBOUNCE_SAMPLES-2:0], btn_sync[1]};
      end
   end

   // Level only moves once the whole window agrees
   always_ff @(posedge clk) begin
      if (!rst_n)
         level <= 1'b0;
      else if (&history)
         level <= 1'b1;
      else if (~|history)
         level <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         level_d <= 1'b0;
         pulse   <= 1'b0;
      end else begin
         level_d <= level;
         pulse   <= level & ~level_d;   // One cycle per press
      end
   end

endmodule

// File: verilog/ping_pong_counter.sv
module ping_pong_counter (
   input  logic                    clk,
   input  logic                    rst_n,
   input  pp_pkg::counter_cfg_t    cfg,
   input  logic                    step,
   input  logic                    flip,
   input  logic                    restart,
   output pp_pkg::counter_state_t  state
);

   import pp_pkg::*;

   dir_e   dir_q;
   dir_e   step_dir;
   count_t count_q;
   count_t step_count;
   logic   limits_ok;

   assign limits_ok = cfg.max > cfg.min;

   // Turn at the limits before taking the step
   always_comb begin
      if (count_q == cfg.min)
         step_dir = DIR_UP;
      else if (count_q == cfg.max)
         step_dir = DIR_DOWN;
      else
         step_dir = dir_q;

      step_count = count_q;
      if (step_dir == DIR_UP && count_q < cfg.max)
         step_count = count_q + 4'd1;
      else if (step_dir == DIR_DOWN && count_q > cfg.min)
         step_count = count_q - 4'd1;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         count_q <= '0;
         dir_q   <= DIR_UP;
      end else if (restart) begin
         count_q <= cfg.min;
         dir_q   <= DIR_UP;
      end else if (flip) begin
         dir_q   <= (dir_q == DIR_UP) ? DIR_DOWN : DIR_UP;   // Count held
      end else if (step && cfg.enable && limits_ok) begin
         count_q <= step_count;
         dir_q   <= step_dir;
      end
   end

   assign state.count = count_q;
   assign state.dir   = dir_q;

   // A step that starts in range stays in range
   a_count_in_range : assert property (@(posedge clk) disable iff (!rst_n)
      step && cfg.enable && limits_ok && count_q >= cfg.min && count_q <= cfg.max
      |=> count_q >= $past(cfg.min) && count_q <= $past(cfg.max));

endmodule

// File: verilog/pp_wb_regs.sv
module pp_wb_regs (
   input  logic                    clk,
   input  logic                    rst_n,
   input  pp_pkg::wb_req_t         wb_req,
   output pp_pkg::wb_rsp_t         wb_rsp,
   input  pp_pkg::counter_state_t  state,
   output pp_pkg::counter_cfg_t    cfg,
   output logic                    sw_flip,
   output logic                    sw_restart
);

   import pp_pkg::*;

   reg_addr_e    addr;
   logic         ack;
   logic         wr_en;
   logic [7:0]   rd_data;
   counter_cfg_t cfg_q;

   assign addr  = reg_addr_e'(wb_req.adr);
   assign wr_en = ack & wb_req.we;   // Lands on the edge that ends the ack cycle

   // Single-cycle ack, then low for at least one cycle
   always_ff @(posedge clk) begin
      if (!rst_n)
         ack <= 1'b0;
      else
         ack <= wb_req.cyc & wb_req.stb & ~ack;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cfg_q <= '0;
      end else if (wr_en) begin
         case (addr)
            REG_CTRL:   cfg_q.enable <= wb_req.dat[0];
            REG_LIMITS: begin
               cfg_q.max <= wb_req.dat[7:4];
               cfg_q.min <= wb_req.dat[3:0];
            end
            default: ;
         endcase
      end
   end

   // Strobes live only in the ack cycle
   assign sw_flip    = wr_en && addr == REG_CMD && wb_req.dat[0];
   assign sw_restart = wr_en && addr == REG_CMD && wb_req.dat[1];

   always_comb begin
      case (addr)
         REG_CTRL:   rd_data = {7'd0, cfg_q.enable};
         REG_LIMITS: rd_data = {cfg_q.max, cfg_q.min};
         REG_STATUS: rd_data = {3'd0, state.dir, state.count};
         default:    rd_data = 8'd0;   // CMD reads as zero
      endcase
   end

   assign wb_rsp.ack = ack;
   assign wb_rsp.dat = rd_data;
   assign cfg        = cfg_q;

   a_ack_single : assert property (@(posedge clk) disable iff (!rst_n)
      ack |=> !ack);

endmodule

// File: verilog/seg_decoder.sv
module seg_decoder (
   input  pp_pkg::digit_kind_e kind,
   input  pp_pkg::count_t      digit,
   output pp_pkg::seg_t        seg
);

   import pp_pkg::*;

   always_comb begin
      if (kind == DIGIT_ARROW) begin
         case (digit)
            4'd1:    seg = 8'b1101_1100;   // Upper arrow, a b f
            4'd0:    seg = 8'b1110_0011;   // Lower arrow, c d e
            default: seg = 8'b1111_1111;
         endcase
      end else begin
         case (digit)
            4'd0:    seg = 8'b1100_0000;
            4'd1:    seg = 8'b1111_1001;
            4'd2:    seg = 8'b1010_0100;
            4'd3:    seg = 8'b1011_0000;
            4'd4:    seg = 8'b1001_1001;
            4'd5:    seg = 8'b1001_0010;
            4'd6:    seg = 8'b1000_0010;
            4'd7:    seg = 8'b1111_1000;
            4'd8:    seg = 8'b1000_0000;
            4'd9:    seg = 8'b1001_0000;
            // Hex letters carry the point
            4'hA:    seg = 8'b0000_1000;
            4'hB:    seg = 8'b0000_0011;
            4'hC:    seg = 8'b0100_0110;
            4'hD:    seg = 8'b0010_0001;
            4'hE:    seg = 8'b0000_0110;
            default: seg = 8'b0000_1110;   // F
         endcase
      end
   end

endmodule

// File: verilog/display_scan.sv
module display_scan (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    scan,
   input  pp_pkg::counter_state_t  state,
   output logic [3:0]              an,
   output pp_pkg::seg_t            seg
);

   import pp_pkg::*;

   logic [1:0]  idx;
   digit_kind_e kind;
   count_t      digit;
   count_t      ones;
   count_t      tens;

   always_ff @(posedge clk) begin
      if (!rst_n)
         idx <= 2'd0;
      else if (scan)
         idx <= idx + 2'd1;   // Wraps 3 to 0
   end

   assign an = ~(4'b0001 << idx);   // One-cold

   // Count never exceeds 15, so tens is 0 or 1
   assign ones = (state.count >= 4'd10) ? state.count - 4'd10 : state.count;
   assign tens = (state.count >= 4'd10) ? 4'd1 : 4'd0;

   always_comb begin
      case (idx)
         2'd2: begin
            kind  = DIGIT_NUMBER;
            digit = ones;
         end
         2'd3: begin
            kind  = DIGIT_NUMBER;
            digit = tens;
         end
         default: begin
            kind  = DIGIT_ARROW;   // Both left digits show the direction
            digit = {3'd0, state.dir};
         end
      endcase
   end

   seg_decoder u_seg_decoder (
      .kind  (kind),
      .digit (digit),
      .seg   (seg)
   );

   a_one_anode : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot(~an));

endmodule

// File: verilog/pp_counter_top.sv
module pp_counter_top #(
   parameter int STEP_DIV = 50_000_000,
   parameter int SCAN_DIV = 100_000
) (
   input  logic             clk,
   input  logic             rst_n,
   input  pp_pkg::wb_req_t  wb_req,
   output pp_pkg::wb_rsp_t  wb_rsp,
   input  logic             flip_btn,
   output pp_pkg::seg_t     seg,
   output logic [3:0]       an
);

   import pp_pkg::*;

   logic           step_tick;
   logic           scan_tick;
   logic           btn_pulse;
   logic           sw_flip;
   logic           sw_restart;
   logic           flip;
   counter_cfg_t   cfg;
   counter_state_t state;

   assign flip = btn_pulse | sw_flip;   // Button and register flip share one path

   tick_gen #(.DIV(STEP_DIV)) step_tick_gen (
      .clk   (clk),
      .rst_n (rst_n),
      .tick  (step_tick)
   );

   tick_gen #(.DIV(SCAN_DIV)) scan_tick_gen (
      .clk   (clk),
      .rst_n (rst_n),
      .tick  (scan_tick)
   );

   button_conditioner u_button_conditioner (
      .clk    (clk),
      .rst_n  (rst_n),
      .sample (scan_tick),
      .btn    (flip_btn),
      .pulse  (btn_pulse)
   );

   ping_pong_counter u_ping_pong_counter (
      .clk     (clk),
      .rst_n   (rst_n),
      .cfg     (cfg),
      .step    (step_tick),
      .flip    (flip),
      .restart (sw_restart),
      .state   (state)
   );

   pp_wb_regs u_pp_wb_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .wb_req     (wb_req),
      .wb_rsp     (wb_rsp),
      .state      (state),
      .cfg        (cfg),
      .sw_flip    (sw_flip),
      .sw_restart (sw_restart)
   );

   display_scan u_display_scan (
      .clk   (clk),
      .rst_n (rst_n),
      .scan  (scan_tick),
      .state (state),
      .an    (an),
      .seg   (seg)
   );

endmodule

// File: sim/tb_pp_counter.sv
module tb_pp_counter;

   import pp_pkg::*;

   localparam int CLK_PERIOD = 100;
   // Cycle budget of each test in run order
   localparam int BUDGET = 60 + 420 + 220 + 260 + 60 + 180;
   localparam int MARGIN = 200;
   localparam seg_t DIGIT_SEG [10] = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99,
                                       8'h92, 8'h82, 8'hF8, 8'h80, 8'h90};

   logic        clk = 1'b0;
   logic        rst_n;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic        flip_btn;
   seg_t        seg;
   logic [3:0]  an;
   logic [15:0] lfsr = 16'd21936;
   int          errors;
   int          tests;
   int          errors_at_start;
   logic        rd_check;
   logic [7:0]  rd_expect;
   logic        disp_check;
   int          disp_count;
   logic        disp_up;

   pp_counter_top #(.STEP_DIV(16), .SCAN_DIV(2)) UUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp),
      .flip_btn (flip_btn),
      .seg      (seg),
      .an       (an)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic log_error(input string msg);
      errors++;
      $display("error at %0t: %s", $time, msg);
   endtask

   // Galois LFSR stepped once per bit taken
   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[6:0], lfsr[0]};
         lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;
      end
      return r;
   endfunction

   function automatic seg_t expected_seg(input logic [3:0] an_n, input int cnt, input logic up);
      case (an_n)
         4'b1110, 4'b1101: return up ? 8'hDC : 8'hE3;   // Arrows a b f or c d e
         4'b1011: return DIGIT_SEG[cnt % 10];
         4'b0111: return DIGIT_SEG[cnt / 10];
         default: return 8'h00;
      endcase
   endfunction

   // Starts on a rising edge and returns one idle cycle after ack
   task automatic wb_access(input logic we, input reg_addr_e adr, input logic [7:0] wdat,
                            output logic [7:0] rdat);
      int waited;
      waited = 0;
      wb_req <= {1'b1, 1'b1, we, adr, wdat};
      do begin
         @(posedge clk);
         waited++;
      end while (!wb_rsp.ack && waited < 8);
      if (!wb_rsp.ack) begin
         errors++;
         $display("Wishbone access to register %0d was never acknowledged", adr);
      end
      rdat = wb_rsp.dat;
      wb_req <= '0;
      @(posedge clk);
   endtask

   task automatic wb_write(input reg_addr_e adr, input logic [7:0] wdat);
      logic [7:0] unused;
      wb_access(1'b1, adr, wdat, unused);
   endtask

   task automatic read_expect(input reg_addr_e adr, input logic [7:0] value);
      logic [7:0] rdat;
      rd_expect = value;
      rd_check  = 1'b1;
      wb_access(1'b0, adr, 8'd0, rdat);
      rd_check  = 1'b0;
   endtask

   task automatic hold_check(input int reads);
      logic [7:0] first;
      wb_access(1'b0, REG_STATUS, 8'd0, first);
      repeat (reads) read_expect(REG_STATUS, first);
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("test %0d (%s) finished with %0d errors", tests, name, errors - errors_at_start);
      errors_at_start = errors;
   endtask

   a_ack_one_cycle : assert property (@(posedge clk) disable iff (!rst_n)
      wb_rsp.ack |=> !wb_rsp.ack) else log_error("ack lasted more than one cycle");
   a_ack_after_stb : assert property (@(posedge clk) disable iff (!rst_n)
      wb_req.cyc && wb_req.stb && !wb_rsp.ack |=> wb_rsp.ack)
      else log_error("ack did not come one cycle after stb");
   a_read_data : assert property (@(posedge clk) disable iff (!rst_n)
      wb_rsp.ack && !wb_req.we && rd_check |-> wb_rsp.dat == rd_expect)
      else log_error($sformatf("read %h, expected %h", $sampled(wb_rsp.dat), rd_expect));
   a_one_anode : assert property (@(posedge clk) disable iff (!rst_n) $onehot(~an))
      else log_error("anode drive is not one-cold");
   a_display : assert property (@(posedge clk) disable iff (!rst_n)
      disp_check |-> seg == expected_seg(an, disp_count, disp_up))
      else log_error("segment pattern does not match the digit shown");

   initial begin
      #((BUDGET + MARGIN) * CLK_PERIOD);
      $display("Timeout, the tests did not finish within %0d cycles", BUDGET + MARGIN);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      logic [7:0] lim;
      logic [7:0] prev;
      logic [7:0] cur;
      logic [3:0] lo;
      logic [3:0] hi;
      int         moves;
      int         glen;
      rst_n      <= 1'b0;
      wb_req     <= '0;
      flip_btn   <= 1'b0;
      rd_check   = 1'b0;
      disp_check = 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      lim = rand_bits(8);
      wb_write(REG_CTRL, 8'h01);
      read_expect(REG_CTRL, 8'h01);
      wb_write(REG_LIMITS, lim);
      read_expect(REG_LIMITS, lim);
      wb_write(REG_CMD, 8'hFC);   // Command bits clear, upper bits set
      read_expect(REG_CMD, 8'h00);
      wb_write(REG_CTRL, 8'h00);
      read_expect(REG_CTRL, 8'h00);
      finish_test("register access");

      lo = 4'(rand_bits(3));
      hi = lo + 4'd2 + 4'(rand_bits(2));   // At least two steps of range
      wb_write(REG_LIMITS, {hi, lo});
      wb_write(REG_CMD, 8'h02);
      read_expect(REG_STATUS, {4'h1, lo});
      wb_write(REG_CTRL, 8'h01);
      prev  = {4'h1, lo};
      moves = 0;
      repeat (120) begin   // One poll every 3 cycles is faster than a step
         wb_access(1'b0, REG_STATUS, 8'd0, cur);
         assert (cur[3:0] >= lo && cur[3:0] <= hi) else log_error("count left the limits");
         if (cur[3:0] != prev[3:0]) begin
            moves++;
            assert (cur[3:0] == (cur[4] ? prev[3:0] + 4'd1 : prev[3:0] - 4'd1))
               else log_error("count change is not one step in the reported direction");
         end
         if (cur[4] != prev[4])
            assert (prev[3:0] == lo || prev[3:0] == hi)
               else log_error("direction turned away from a limit");
         prev = cur;
      end
      assert (moves >= 15) else log_error("counter stopped stepping");
      finish_test("ping-pong");

      wb_write(REG_CTRL, 8'h00);
      wb_access(1'b0, REG_STATUS, 8'd0, prev);
      repeat (5) begin
         glen = 1 + rand_bits(2) % 3;
         flip_btn <= 1'b1;
         repeat (2 * glen) @(posedge clk);   // glen scan ticks
         flip_btn <= 1'b0;
         repeat (10) @(posedge clk);
      end
      read_expect(REG_STATUS, prev);
      flip_btn <= 1'b1;
      repeat (24) @(posedge clk);   // 12 scan ticks
      flip_btn <= 1'b0;
      repeat (16) @(posedge clk);
      read_expect(REG_STATUS, prev ^ 8'h10);
      finish_test("button flip");

      hold_check(25);
      wb_write(REG_LIMITS, 8'h55);
      wb_write(REG_CTRL, 8'h01);
      hold_check(25);
      wb_write(REG_LIMITS, 8'h38);
      hold_check(10);
      finish_test("hold");

      wb_write(REG_CTRL, 8'h00);
      wb_write(REG_LIMITS, 8'hF2);
      wb_write(REG_CMD, 8'h02);
      wb_write(REG_CMD, 8'h01);
      read_expect(REG_STATUS, 8'h02);   // Down at 2
      wb_write(REG_LIMITS, 8'hF9);
      wb_write(REG_CMD, 8'h02);
      read_expect(REG_STATUS, 8'h19);
      finish_test("software commands");

      for (int i = 0; i < 4; i++) begin
         disp_count = 3 + 4 * i;
         disp_up    = i[0];
         wb_write(REG_LIMITS, {4'hF, 4'(disp_count)});
         wb_write(REG_CMD, 8'h02);
         if (!disp_up)
            wb_write(REG_CMD, 8'h01);
         disp_check = 1'b1;
         repeat (12) @(posedge clk);   // Covers all four digits
         disp_check = 1'b0;
      end
      finish_test("display");

      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// File: sources.f
verilog/pp_pkg.sv
verilog/tick_gen.sv
verilog/button_conditioner.sv
verilog/ping_pong_counter.sv
verilog/pp_wb_regs.sv
verilog/seg_decoder.sv
verilog/display_scan.sv
verilog/pp_counter_top.sv
sim/tb_pp_counter.sv
